/* Makefile */
VERILATOR ?= verilator
TOP ?= nearest_hit_tb
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
PASS_TEXT ?= ALL TESTS PASSED

SIM := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST)) common/hit_consts.svh

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run passes only when the simulation prints the pass message
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* common/hit_consts.svh */
`ifndef HIT_CONSTS_SVH
`define HIT_CONSTS_SVH

// one signed coordinate of a hit point, relative to the ray origin
`define COORD_BITS 16

`define TRI_ID_BITS 12

// three squares of COORD_BITS values need two more bits than one square
`define DIST_BITS (2 * `COORD_BITS + 2)

`define HIT_FIFO_DEPTH 8

`endif

/* common/hit_pkg.sv */
`include "hit_consts.svh"

package hit_pkg;

    typedef struct packed {
        logic signed [`COORD_BITS-1:0] x;
        logic signed [`COORD_BITS-1:0] y;
        logic signed [`COORD_BITS-1:0] z;
    } hit_point_t;

    // one record per tested triangle, last closes the ray
    typedef struct packed {
        logic                    hit;
        logic                    last;
        logic [`TRI_ID_BITS-1:0] tri_id;
        hit_point_t              point;
    } hit_rec_t;

    typedef struct packed {
        hit_rec_t              rec;
        logic [`DIST_BITS-1:0] dist2;
    } dist_rec_t;

    typedef struct packed {
        logic                    hit;
        logic [`TRI_ID_BITS-1:0] tri_id;
        hit_point_t              point;
        logic [`DIST_BITS-1:0]   dist2;
    } ray_result_t;

    typedef enum logic {
        RED_SCAN,
        RED_EMIT
    } reducer_state_t;

endpackage

/* design/hit_fifo.sv */
`timescale 1ns/1ps
`include "hit_consts.svh"

module hit_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = `HIT_FIFO_DEPTH
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [WIDTH-1:0] in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [WIDTH-1:0] out_data
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(DEPTH - 1);
    localparam logic [PTR_BITS:0] FULL_COUNT = (PTR_BITS + 1)'(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0] count;
    logic push;
    logic pop;

    // a full FIFO refuses a write even when the head leaves in the same cycle
    assign in_ready = (count != FULL_COUNT);
    assign out_valid = (count != '0);
    assign out_data = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

/* design/nearest_hit_top.sv */
`timescale 1ns/1ps

module nearest_hit_top (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  hit_pkg::hit_rec_t    in_rec,
    output logic                 out_valid,
    input  logic                 out_ready,
    output hit_pkg::ray_result_t out_result
);
    import hit_pkg::*;

    localparam int REC_BITS = $bits(hit_rec_t);
    localparam int RESULT_BITS = $bits(ray_result_t);

    logic [REC_BITS-1:0] in_flat;
    logic [REC_BITS-1:0] in_fifo_data;
    logic in_fifo_valid;
    logic in_fifo_ready;
    hit_rec_t fifo_rec;

    logic dist_valid;
    logic dist_ready;
    dist_rec_t dist_rec;

    logic red_valid;
    logic red_ready;
    ray_result_t red_result;
    logic [RESULT_BITS-1:0] red_flat;
    logic [RESULT_BITS-1:0] out_fifo_data;

    // the FIFOs store flat words, the structs are restored on the way out
    assign in_flat = in_rec;
    assign fifo_rec = hit_rec_t'(in_fifo_data);
    assign red_flat = red_result;
    assign out_result = ray_result_t'(out_fifo_data);

    hit_fifo #(
        .WIDTH(REC_BITS)
    ) in_fifo (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_flat),
        .out_valid (in_fifo_valid),
        .out_ready (in_fifo_ready),
        .out_data  (in_fifo_data)
    );

    dist_squared dist_squared (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_fifo_valid),
        .in_ready  (in_fifo_ready),
        .in_rec    (fifo_rec),
        .out_valid (dist_valid),
        .out_ready (dist_ready),
        .out_rec   (dist_rec)
    );

    nearest_hit_reducer nearest_hit_reducer (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (dist_valid),
        .in_ready   (dist_ready),
        .in_rec     (dist_rec),
        .out_valid  (red_valid),
        .out_ready  (red_ready),
        .out_result (red_result)
    );

    hit_fifo #(
        .WIDTH(RESULT_BITS)
    ) out_fifo (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (red_valid),
        .in_ready  (red_ready),
        .in_data   (red_flat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_fifo_data)
    );

endmodule

/* nearest_hit/dist_squared.sv */
`timescale 1ns/1ps
`include "hit_consts.svh"

module dist_squared (
    input  logic               clock,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    input  hit_pkg::hit_rec_t  in_rec,
    output logic               out_valid,
    input  logic               out_ready,
    output hit_pkg::dist_rec_t out_rec
);
    import hit_pkg::*;

    localparam int SQ_BITS = 2 * `COORD_BITS;
    localparam int DIST_W = `DIST_BITS;

    logic s1_valid;
    hit_rec_t s1_rec;
    logic [SQ_BITS-1:0] s1_sq_x;
    logic [SQ_BITS-1:0] s1_sq_y;
    logic [SQ_BITS-1:0] s1_sq_z;
    logic s2_valid;
    dist_rec_t s2_rec;
    logic advance;

    // the square of the most negative coordinate still fits in SQ_BITS
    function automatic logic [SQ_BITS-1:0] square(input logic signed [`COORD_BITS-1:0] c);
        logic signed [SQ_BITS-1:0] wide;
        wide = SQ_BITS'(c) * SQ_BITS'(c);
        return wide;
    endfunction

    // both stages move together whenever the output slot is free or being taken
    assign advance = !s2_valid || out_ready;
    assign in_ready = advance;

    assign out_valid = s2_valid;
    assign out_rec = s2_rec;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
            s2_valid <= s1_valid;
        end
    end

    // records without a hit still pass because they carry the last flag to the reducer
    always_ff @(posedge clock) begin
        if (advance) begin
            if (in_valid) begin
                s1_rec <= in_rec;
                s1_sq_x <= square(in_rec.point.x);
                s1_sq_y <= square(in_rec.point.y);
                s1_sq_z <= square(in_rec.point.z);
            end
            if (s1_valid) begin
                s2_rec.rec <= s1_rec;
                s2_rec.dist2 <= DIST_W'(s1_sq_x) + DIST_W'(s1_sq_y) + DIST_W'(s1_sq_z);
            end
        end
    end

endmodule

/* nearest_hit/nearest_hit_reducer.sv */
`timescale 1ns/1ps

module nearest_hit_reducer (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  hit_pkg::dist_rec_t   in_rec,
    output logic                 out_valid,
    input  logic                 out_ready,
    output hit_pkg::ray_result_t out_result
);
    import hit_pkg::*;

    // empty ray: no hit, ID 0, origin point and the largest distance
    localparam ray_result_t NO_HIT = '{hit: 1'b0, tri_id: '0, point: '0, dist2: '1};

    reducer_state_t state;
    ray_result_t best;
    ray_result_t folded;
    ray_result_t result;
    logic accept;
    logic closer;

    // the result waits in RED_EMIT, so no record is taken until it leaves
    assign in_ready = (state == RED_SCAN);
    assign out_valid = (state == RED_EMIT);
    assign out_result = result;

    assign accept = in_valid && in_ready;

    // strict compare, so of two equal distances the earlier hit stays
    assign closer = in_rec.rec.hit && (in_rec.dist2 < best.dist2);

    always_comb begin
        folded = best;
        if (closer) begin
            folded.hit = 1'b1;
            folded.tri_id = in_rec.rec.tri_id;
            folded.point = in_rec.rec.point;
            folded.dist2 = in_rec.dist2;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= RED_SCAN;
            best <= NO_HIT;
        end else begin
            case (state)
                RED_SCAN: begin
                    if (accept) begin
                        if (in_rec.rec.last) begin
                            // the next ray starts from scratch
                            best <= NO_HIT;
                            state <= RED_EMIT;
                        end else begin
                            best <= folded;
                        end
                    end
                end
                RED_EMIT: begin
                    if (out_ready) begin
                        state <= RED_SCAN;
                    end
                end
                default: begin
                    state <= RED_SCAN;
                end
            endcase
        end
    end

    // the last record is folded in before the result is captured
    always_ff @(posedge clock) begin
        if (accept && in_rec.rec.last) begin
            result <= folded;
        end
    end

endmodule

/* tb.f */
+incdir+common
common/hit_pkg.sv
design/hit_fifo.sv
nearest_hit/dist_squared.sv
nearest_hit/nearest_hit_reducer.sv
design/nearest_hit_top.sv
verif/nearest_hit_assert.sv
verif/nearest_hit_tb.sv

/* verif/nearest_hit_assert.sv */
`timescale 1ns/1ps

module nearest_hit_assert (
    input logic                 clock,
    input logic                 reset,
    input logic                 in_valid,
    input logic                 in_ready,
    input hit_pkg::hit_rec_t    in_rec,
    input logic                 out_valid,
    input logic                 out_ready,
    input hit_pkg::ray_result_t out_result
);

    no_output_in_reset: assert property (@(posedge clock) reset |-> !out_valid)
        else $error("out_valid is high while reset is asserted");

    // a waiting result must not change or vanish
    result_held: assert property (@(posedge clock) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_result))
        else $error("out_result changed while waiting for out_ready");

    record_held: assert property (@(posedge clock) disable iff (reset)
        in_valid && !in_ready |=> $stable(in_rec))
        else $error("in_rec changed while waiting for in_ready");

endmodule

bind nearest_hit_top nearest_hit_assert handshake_checks (
    .clock      (clock),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_rec     (in_rec),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_result (out_result)
);

/* verif/nearest_hit_tb.sv */
`timescale 1ns/1ps
`include "hit_consts.svh"

module nearest_hit_tb;
    import hit_pkg::*;

    localparam int CLOCK_PERIOD = 4;
    localparam int DIRECTED_RAYS = 6;
    localparam int RANDOM_RAYS = 40;
    localparam int STALL_RAYS = 30;
    localparam int TOTAL_RAYS = DIRECTED_RAYS + RANDOM_RAYS + STALL_RAYS;
    // a ray carries at most 16 records, each is given 10 cycles
    localparam int TIMEOUT_CYCLES = TOTAL_RAYS * 16 * 10 + 2000;

    logic clock;
    logic reset;
    logic in_valid;
    logic in_ready;
    hit_rec_t in_rec;
    logic out_valid;
    logic out_ready;
    ray_result_t out_result;

    logic [15:0] lfsr;
    logic [`TRI_ID_BITS-1:0] next_id;
    hit_rec_t ray_buf[$];
    hit_rec_t stim[$];
    ray_result_t expected_q[$];
    int ray_count;
    int result_count;
    int error_count;
    logic saw_input_stall;
    int dir_end;
    int rand_end;
    int stall_end;

    nearest_hit_top DUT (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_rec     (in_rec),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_result (out_result)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic longint square_sum(input hit_point_t p);
        longint x;
        longint y;
        longint z;
        x = longint'($signed(p.x));
        y = longint'($signed(p.y));
        z = longint'($signed(p.z));
        return x * x + y * y + z * z;
    endfunction

    // reference: closest hit wins, a tie keeps the earlier record
    function automatic ray_result_t expected_result();
        ray_result_t res;
        longint best_d;
        longint d;
        res.hit = 1'b0;
        res.tri_id = '0;
        res.point = '0;
        res.dist2 = '1;
        best_d = (longint'(1) << `DIST_BITS) - 1;
        foreach (ray_buf[i]) begin
            if (ray_buf[i].hit) begin
                d = square_sum(ray_buf[i].point);
                if (d < best_d) begin
                    best_d = d;
                    res.hit = 1'b1;
                    res.tri_id = ray_buf[i].tri_id;
                    res.point = ray_buf[i].point;
                    res.dist2 = d[`DIST_BITS-1:0];
                end
            end
        end
        return res;
    endfunction

    task automatic add_record(input logic hit, input int x, input int y, input int z);
        hit_rec_t r;
        r.hit = hit;
        r.last = 1'b0;
        r.tri_id = next_id;
        r.point.x = x[`COORD_BITS-1:0];
        r.point.y = y[`COORD_BITS-1:0];
        r.point.z = z[`COORD_BITS-1:0];
        next_id = next_id + 1'b1;
        ray_buf.push_back(r);
    endtask

    task automatic close_ray();
        hit_rec_t r;
        r = ray_buf.pop_back();
        r.last = 1'b1;
        ray_buf.push_back(r);
        expected_q.push_back(expected_result());
        foreach (ray_buf[i]) begin
            stim.push_back(ray_buf[i]);
        end
        ray_buf.delete();
        ray_count++;
    endtask

    task automatic add_random_ray(input int len);
        int i;
        logic hit;
        int x;
        int y;
        int z;
        for (i = 0; i < len; i++) begin
            hit = (random_bits(1) != 0);
            x = int'(random_bits(16));
            y = int'(random_bits(16));
            z = int'(random_bits(16));
            add_record(hit, x, y, z);
        end
        close_ray();
    endtask

    task automatic build_directed_rays();
        // several hits, plus a close point whose hit flag is clear
        add_record(1'b1, 100, 0, 0);
        add_record(1'b0, 1, 0, 0);
        add_record(1'b1, 0, -20, 1);
        add_record(1'b1, 30, 30, 30);
        add_record(1'b1, -7, 8, -9);
        close_ray();
        add_record(1'b0, 0, 0, 0);
        add_record(1'b0, 5, 5, 5);
        add_record(1'b0, -1, 2, -3);
        add_record(1'b0, 9, 0, 0);
        close_ray();
        // equal distances of 25, the first one must stay
        add_record(1'b1, 3, 4, 0);
        add_record(1'b1, 0, 0, 5);
        add_record(1'b1, -4, 3, 0);
        add_record(1'b1, 0, 5, 0);
        close_ray();
        add_record(1'b1, 6, 0, 0);
        add_record(1'b1, 0, -3, 4);
        add_record(1'b1, 0, 4, -3);
        add_record(1'b1, 5, 0, 0);
        close_ray();
        add_record(1'b1, -32768, -32768, -32768);
        add_record(1'b1, 32767, 32767, 32767);
        add_record(1'b1, -32768, 0, 32767);
        close_ray();
        add_record(1'b1, -32768, -32768, -32768);
        close_ray();
    endtask

    // mode 0 keeps out_ready high, mode 1 is random, mode 2 stalls until in_ready drops
    function automatic logic pick_out_ready(input int mode, input int full_cycles);
        if (mode == 0) begin
            return 1'b1;
        end
        if (mode == 2 && full_cycles < 8) begin
            return 1'b0;
        end
        return (random_bits(2) != 0);
    endfunction

    task automatic drive_records(input int first, input int count, input int mode);
        int idx;
        int full_cycles;
        logic took;
        idx = first;
        full_cycles = 0;
        while (idx < first + count) begin
            @(negedge clock);
            took = in_valid && in_ready;
            if (in_valid && !in_ready) begin
                full_cycles++;
                if (mode == 2) begin
                    saw_input_stall = 1'b1;
                end
            end
            @(posedge clock);
            #1;
            if (took) begin
                idx++;
            end
            out_ready = pick_out_ready(mode, full_cycles);
            if (in_valid && !took) begin
                in_valid = 1'b1;
            end else if (idx < first + count && (mode == 0 || random_bits(2) != 0)) begin
                in_valid = 1'b1;
                in_rec = stim[idx];
            end else begin
                in_valid = 1'b0;
            end
        end
    endtask

    task automatic value_error(input string field, input longint expected, input longint actual);
        $display("Error at %0t: ray %0d %s expected %0d, got %0d",
                 $time, result_count, field, expected, actual);
        error_count++;
    endtask

    // outputs only change at the rising edge, so the falling edge sees the transfer data
    always @(negedge clock) begin
        ray_result_t exp;
        if (!reset && out_valid && out_ready) begin
            if (expected_q.size() == 0) begin
                $display("A result arrived at %0t with no ray waiting for it", $time);
                error_count++;
            end else begin
                exp = expected_q.pop_front();
                if (out_result.hit !== exp.hit) begin
                    value_error("hit", longint'(exp.hit), longint'(out_result.hit));
                end
                if (out_result.tri_id !== exp.tri_id) begin
                    value_error("tri_id", longint'(exp.tri_id), longint'(out_result.tri_id));
                end
                if (out_result.point.x !== exp.point.x) begin
                    value_error("x", longint'($signed(exp.point.x)),
                                longint'($signed(out_result.point.x)));
                end
                if (out_result.point.y !== exp.point.y) begin
                    value_error("y", longint'($signed(exp.point.y)),
                                longint'($signed(out_result.point.y)));
                end
                if (out_result.point.z !== exp.point.z) begin
                    value_error("z", longint'($signed(exp.point.z)),
                                longint'($signed(out_result.point.z)));
                end
                if (out_result.dist2 !== exp.dist2) begin
                    value_error("dist2", longint'(exp.dist2), longint'(out_result.dist2));
                end
            end
            result_count++;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLOCK_PERIOD);
        $display("Timeout: only %0d of %0d results arrived", result_count, ray_count);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        clock = 1'b0;
        reset = 1'b1;
        in_valid = 1'b0;
        in_rec = '0;
        out_ready = 1'b0;
        lfsr = 16'd43;
        next_id = 1;
        ray_count = 0;
        result_count = 0;
        error_count = 0;
        saw_input_stall = 1'b0;

        build_directed_rays();
        dir_end = stim.size();
        repeat (RANDOM_RAYS) begin
            add_random_ray(int'(random_bits(4)) + 1);
        end
        rand_end = stim.size();
        // single-record rays fill both FIFOs quickly while the output is stalled
        repeat (STALL_RAYS) begin
            add_random_ray(1);
        end
        stall_end = stim.size();

        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        if (out_valid !== 1'b0) begin
            $display("Error at %0t: out_valid is high right after reset", $time);
            error_count++;
        end
        if (in_ready !== 1'b1) begin
            $display("Error at %0t: in_ready is low right after reset", $time);
            error_count++;
        end

        drive_records(0, dir_end, 0);
        drive_records(dir_end, rand_end - dir_end, 1);
        drive_records(rand_end, stall_end - rand_end, 2);

        @(posedge clock);
        #1;
        out_ready = 1'b1;
        wait (result_count == ray_count);
        repeat (10) @(posedge clock);

        if (!saw_input_stall) begin
            $display("in_ready never dropped during the long output stall");
            error_count++;
        end
        if (expected_q.size() != 0) begin
            $display("%0d expected results were never received", expected_q.size());
            error_count++;
        end
        $display("errors: %0d, results received: %0d of %0d", error_count, result_count,
                 ray_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
